/* whack_pkg.sv */
package whack_pkg;

  typedef enum logic [1:0] {
    INIT  = 2'd0,
    SET   = 2'd1,
    GAME  = 2'd2,
    FINAL = 2'd3
  } game_state_t;

  typedef struct packed {
    logic       valid;
    logic       make;   // 1 press, 0 release
    logic [8:0] code;   // bit 8 marks an extended code
  } key_event_t;

  typedef struct packed {
    logic       valid;
    logic       is_space;
    logic       is_digit;
    logic [3:0] digit;
  } stroke_t;

  typedef struct packed {
    logic [7:0] time_bcd;
    logic [7:0] goal_bcd;
    logic       set_goal;  // entry mode, 0 = time
  } game_cfg_t;

  typedef struct packed {
    logic [7:0] score;
    logic [7:0] remaining;
    logic       win;
    logic       done;
  } play_t;

  localparam int TICK_CYCLES = 16;  // clock cycles per game second
  localparam int TICK_W = $clog2(TICK_CYCLES);
  localparam int FINAL_TICKS = 5;
  localparam int HOLD_W = $clog2(FINAL_TICKS);

  localparam logic [8:0] LFSR_SEED = 9'h160;
  localparam logic [8:0] SPACE_CODE = 9'h029;

  // main row 0-9 then keypad 0-9
  localparam int KEY_COUNT = 20;
  localparam logic [8:0] KEY_CODE [KEY_COUNT] = '{
    9'h045, 9'h016, 9'h01E, 9'h026, 9'h025,
    9'h02E, 9'h036, 9'h03D, 9'h03E, 9'h046,
    9'h070, 9'h069, 9'h072, 9'h07A, 9'h06B,
    9'h073, 9'h074, 9'h06C, 9'h075, 9'h07D
  };

  localparam logic [15:0] WIN_NUMS = 16'hFABC;
  localparam logic [15:0] LOSE_NUMS = 16'hD05E;
  localparam logic [15:0] IDLE_NUMS = 16'hFFFF;

  localparam logic [15:0] LED_IDLE = 16'h8001;
  localparam logic [15:0] LED_SET_TIME = 16'hFF01;
  localparam logic [15:0] LED_SET_GOAL = 16'h80FF;
  localparam logic [6:0] LED_GAME_TAIL = 7'b0000011;

  localparam logic [7:0] DEF_TIME_BCD = 8'h30;
  localparam logic [7:0] DEF_GOAL_BCD = 8'h10;

  function automatic logic [7:0] bcd_to_bin(input logic [7:0] bcd);
    return 8'(bcd[7:4]) * 8'd10 + 8'(bcd[3:0]);
  endfunction

  // two digits only, values above 99 wrap in the tens digit
  function automatic logic [7:0] bin_to_bcd(input logic [7:0] bin);
    logic [7:0] tens;
    logic [7:0] units;
    tens = bin / 8'd10;
    units = bin % 8'd10;
    return {tens[3:0], units[3:0]};
  endfunction

endpackage

/* key_mapper.sv */
`timescale 1ns/100ps

module key_mapper (
  input  logic                  clk,
  input  logic                  out_rst,
  input  whack_pkg::key_event_t key,
  output whack_pkg::stroke_t    stroke
);
  import whack_pkg::*;

  logic       is_digit;
  logic       is_space;
  logic       is_repeat;
  logic [3:0] digit;
  logic [8:0] last_code;
  logic       held;

  // table lookup, both digit rows give 0-9
  always_comb begin
    is_digit = 1'b0;
    digit = 4'd0;
    for (int i = 0; i < KEY_COUNT; i++) begin
      if (key.code == KEY_CODE[i]) begin
        is_digit = 1'b1;
        digit = 4'(i % 10);
      end
    end
  end

  assign is_space = key.code == SPACE_CODE;
  assign is_repeat = held && key.code == last_code;  // typematic

  always_ff @(posedge clk or posedge out_rst) begin
    if (out_rst) begin
      stroke <= '0;
      last_code <= '0;
      held <= 1'b0;
    end else begin
      stroke.valid <= 1'b0;
      if (key.valid && key.make) begin
        stroke.valid <= (is_digit || is_space) && !is_repeat;
        stroke.is_space <= is_space;
        stroke.is_digit <= is_digit;
        stroke.digit <= digit;
        last_code <= key.code;
        held <= 1'b1;
      end else if (key.valid && key.code == last_code) begin
        held <= 1'b0;  // break of the held key
      end
    end
  end

endmodule

/* game_fsm.sv */
`timescale 1ns/100ps

module game_fsm (
  input  logic                   clk,
  input  logic                   out_rst,
  input  logic                   start,
  input  logic                   done,
  input  logic                   hold_done,
  output whack_pkg::game_state_t state
);
  import whack_pkg::*;

  game_state_t next_state;

  always_comb begin
    next_state = state;
    unique case (state)
      INIT: begin
        if (start) next_state = SET;
      end
      SET: begin
        if (start) next_state = GAME;
      end
      GAME: begin
        // start ignored here
        if (done) next_state = FINAL;
      end
      FINAL: begin
        if (hold_done) next_state = INIT;
      end
      default: next_state = INIT;
    endcase
  end

  always_ff @(posedge clk or posedge out_rst) begin
    if (out_rst) begin
      state <= INIT;
    end else begin
      state <= next_state;
    end
  end

endmodule

/* game_timer.sv */
`timescale 1ns/100ps

module game_timer (
  input  logic                   clk,
  input  logic                   out_rst,
  input  whack_pkg::game_state_t state,
  input  logic [7:0]             time_bcd,
  output logic                   tick,
  output logic [7:0]             remaining,
  output logic                   time_up,
  output logic                   hold_done
);
  import whack_pkg::*;

  game_state_t       prev_state;
  logic              state_chg;
  logic [TICK_W-1:0] presc;
  logic [HOLD_W-1:0] hold_cnt;

  assign state_chg = state != prev_state;
  assign tick = presc == TICK_W'(TICK_CYCLES - 1) && !state_chg;
  assign time_up = remaining == 8'd0;
  assign hold_done = state == FINAL && tick && hold_cnt == HOLD_W'(FINAL_TICKS - 1);

  // prescaler restarts on every state change
  always_ff @(posedge clk or posedge out_rst) begin
    if (out_rst) begin
      prev_state <= INIT;
      presc <= '0;
    end else begin
      prev_state <= state;
      if (state_chg) begin
        presc <= '0;
      end else if (tick) begin
        presc <= '0;
      end else begin
        presc <= presc + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or posedge out_rst) begin
    if (out_rst) begin
      remaining <= bcd_to_bin(DEF_TIME_BCD);
    end else if (state == SET) begin
      remaining <= bcd_to_bin(time_bcd);
    end else if (state == GAME && tick && !time_up) begin
      remaining <= remaining - 1'b1;
    end
  end

  // seconds spent showing the result
  always_ff @(posedge clk or posedge out_rst) begin
    if (out_rst) begin
      hold_cnt <= '0;
    end else if (state != FINAL) begin
      hold_cnt <= '0;
    end else if (tick) begin
      hold_cnt <= hold_cnt + 1'b1;
    end
  end

endmodule

/* mole_lfsr.sv */
`timescale 1ns/100ps

module mole_lfsr (
  input  logic                   clk,
  input  logic                   out_rst,
  input  whack_pkg::game_state_t state,
  input  logic                   tick,
  output logic [8:0]             moles
);
  import whack_pkg::*;

  logic [8:0] next_moles;

  // shift right, bit 0 fed back into 8, 6, 5 and 3
  always_comb begin
    next_moles[8] = moles[0];
    next_moles[7] = moles[8];
    next_moles[6] = moles[7] ^ moles[0];
    next_moles[5] = moles[6] ^ moles[0];
    next_moles[4] = moles[5];
    next_moles[3] = moles[4] ^ moles[0];
    next_moles[2] = moles[3];
    next_moles[1] = moles[2];
    next_moles[0] = moles[1];
  end

  always_ff @(posedge clk or posedge out_rst) begin
    if (out_rst) begin
      moles <= LFSR_SEED;
    end else if (state != GAME) begin
      moles <= LFSR_SEED;  // same pattern every game
    end else if (tick) begin
      moles <= next_moles;
    end
  end

endmodule

/* score_keeper.sv */
`timescale 1ns/100ps

module score_keeper (
  input  logic                   clk,
  input  logic                   out_rst,
  input  whack_pkg::game_state_t state,
  input  whack_pkg::stroke_t     stroke,
  input  logic [8:0]             moles,
  input  logic [7:0]             remaining,
  input  logic                   time_up,
  output whack_pkg::game_cfg_t   cfg,
  output whack_pkg::play_t       play
);
  import whack_pkg::*;

  logic [7:0] goal_bin;
  logic       hit;

  assign goal_bin = bcd_to_bin(cfg.goal_bcd);

  // digit k hits mole bit 9-k, zero never hits
  assign hit = stroke.valid && stroke.is_digit && stroke.digit != 4'd0 &&
               moles[4'd9 - stroke.digit];

  always_ff @(posedge clk or posedge out_rst) begin
    if (out_rst) begin
      cfg.time_bcd <= DEF_TIME_BCD;
      cfg.goal_bcd <= DEF_GOAL_BCD;
      cfg.set_goal <= 1'b0;
      play <= '0;
    end else begin
      unique case (state)
        INIT: begin
          cfg.time_bcd <= DEF_TIME_BCD;
          cfg.goal_bcd <= DEF_GOAL_BCD;
          cfg.set_goal <= 1'b0;
          play <= '0;
        end
        SET: begin
          if (stroke.valid && stroke.is_space) begin
            cfg.set_goal <= ~cfg.set_goal;
          end else if (stroke.valid && stroke.is_digit) begin
            // old units digit moves up to tens
            if (cfg.set_goal) begin
              cfg.goal_bcd <= {cfg.goal_bcd[3:0], stroke.digit};
            end else begin
              cfg.time_bcd <= {cfg.time_bcd[3:0], stroke.digit};
            end
          end
        end
        GAME: begin
          if (!play.done) begin
            play.remaining <= remaining;  // frozen once done
            if (play.score == goal_bin) begin
              play.done <= 1'b1;
              play.win <= 1'b1;
            end else if (time_up) begin
              play.done <= 1'b1;
              play.win <= 1'b0;
            end else if (hit) begin
              play.score <= play.score + 1'b1;
            end
          end
        end
        FINAL: begin
          play <= play;  // result stays for display
        end
        default: play <= '0;
      endcase
    end
  end

endmodule

/* led_display.sv */
`timescale 1ns/100ps

module led_display (
  input  logic                   clk,
  input  logic                   out_rst,
  input  whack_pkg::game_state_t state,
  input  logic                   tick,
  input  whack_pkg::game_cfg_t   cfg,
  input  whack_pkg::play_t       play,
  input  logic [7:0]             remaining,
  input  logic [8:0]             moles,
  output logic [15:0]            led,
  output logic [15:0]            nums
);
  import whack_pkg::*;

  logic        in_final;
  logic [7:0]  rem_shown;
  logic [15:0] next_led;
  logic [15:0] next_nums;

  // hold the finishing time once the game is decided
  assign rem_shown = play.done ? play.remaining : remaining;

  always_comb begin
    next_led = led;
    next_nums = nums;
    unique case (state)
      INIT: begin
        next_led = LED_IDLE;
        next_nums = IDLE_NUMS;
      end
      SET: begin
        next_led = cfg.set_goal ? LED_SET_GOAL : LED_SET_TIME;
        next_nums = {cfg.time_bcd, cfg.goal_bcd};
      end
      GAME: begin
        next_led = {moles, LED_GAME_TAIL};
        next_nums = {bin_to_bcd(rem_shown), bin_to_bcd(play.score)};
      end
      FINAL: begin
        if (!in_final) begin
          next_led = '1;  // flash starts lit
        end else if (tick) begin
          next_led = ~led;
        end
        next_nums = play.win ? WIN_NUMS : LOSE_NUMS;
      end
      default: begin
        next_led = LED_IDLE;
        next_nums = IDLE_NUMS;
      end
    endcase
  end

  always_ff @(posedge clk or posedge out_rst) begin
    if (out_rst) begin
      led <= LED_IDLE;
      nums <= IDLE_NUMS;
      in_final <= 1'b0;
    end else begin
      led <= next_led;
      nums <= next_nums;
      in_final <= state == FINAL;
    end
  end

endmodule

/* whack_top.sv */
`timescale 1ns/100ps

module whack_top (
  input  logic                  clk,
  input  logic                  out_rst,
  input  logic                  start,
  input  whack_pkg::key_event_t key,
  output logic [15:0]           led,
  output logic [15:0]           nums
);
  import whack_pkg::*;

  game_state_t state;
  stroke_t     stroke;
  game_cfg_t   cfg;
  play_t       play;
  logic        tick;
  logic        time_up;
  logic        hold_done;
  logic [7:0]  remaining;
  logic [8:0]  moles;

  key_mapper key_mapper_i (
    .clk     (clk),
    .out_rst (out_rst),
    .key     (key),
    .stroke  (stroke)
  );

  game_fsm game_fsm_i (
    .clk       (clk),
    .out_rst   (out_rst),
    .start     (start),
    .done      (play.done),
    .hold_done (hold_done),
    .state     (state)
  );

  game_timer game_timer_i (
    .clk       (clk),
    .out_rst   (out_rst),
    .state     (state),
    .time_bcd  (cfg.time_bcd),
    .tick      (tick),
    .remaining (remaining),
    .time_up   (time_up),
    .hold_done (hold_done)
  );

  mole_lfsr mole_lfsr_i (
    .clk     (clk),
    .out_rst (out_rst),
    .state   (state),
    .tick    (tick),
    .moles   (moles)
  );

  score_keeper score_keeper_i (
    .clk       (clk),
    .out_rst   (out_rst),
    .state     (state),
    .stroke    (stroke),
    .moles     (moles),
    .remaining (remaining),
    .time_up   (time_up),
    .cfg       (cfg),
    .play      (play)
  );

  led_display led_display_i (
    .clk       (clk),
    .out_rst   (out_rst),
    .state     (state),
    .tick      (tick),
    .cfg       (cfg),
    .play      (play),
    .remaining (remaining),
    .moles     (moles),
    .led       (led),
    .nums      (nums)
  );

endmodule

/* tb_whack.sv */
`timescale 1ns/100ps

module tb_whack;
  import whack_pkg::*;

  localparam int CLK_PERIOD = 20;
  // two entries, longest game, two flashes, margin
  localparam int RUN_TICKS = 8 + 46 + 6 + 8 + 4 + 6 + 10;

  logic        clk;
  logic        out_rst;
  logic        start;
  key_event_t  key;
  logic [15:0] led;
  logic [15:0] nums;

  int          check_errors;
  int          other_errors;
  string       test_name;
  logic [31:0] rng;
  bit          game_window;  // high while the tb model says GAME
  int          score;

  whack_top dut_i (
    .clk     (clk),
    .out_rst (out_rst),
    .start   (start),
    .key     (key),
    .led     (led),
    .nums    (nums)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // shift right, bit 0 folds back into 8, 6, 5 and 3
  function automatic logic [8:0] lfsr_step(input logic [8:0] s);
    return s[0] ? (s >> 1) ^ 9'h168 : s >> 1;
  endfunction

  function automatic logic [7:0] two_digits(input int v);
    return {4'(v / 10), 4'(v % 10)};
  endfunction

  task automatic compare(input string what, input logic [15:0] exp, input logic [15:0] act);
    assert (act === exp) else begin
      check_errors++;
      $display("CHECK FAILED %s, %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  assert property (@(posedge clk) out_rst |=> led == 16'h8001 && nums == 16'hFFFF)
    else begin
      check_errors++;
      $display("CHECK FAILED %s, reset: expected 8001 ffff, actual %h %h",
               test_name, $sampled(led), $sampled(nums));
    end

  assert property (@(posedge clk) disable iff (out_rst) game_window |-> led[6:0] == 7'b0000011)
    else begin
      check_errors++;
      $display("CHECK FAILED %s, led tail: expected 0000011, actual %b",
               test_name, $sampled(led[6:0]));
    end

  task automatic send_key(input logic [8:0] code, input logic make);
    @(posedge clk);
    key <= {1'b1, make, code};
    @(posedge clk);
    key <= '0;
  endtask

  task automatic press(input logic [8:0] code);
    send_key(code, 1'b1);
    send_key(code, 1'b0);
  endtask

  task automatic pulse_start();
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
  endtask

  task automatic settle();
    repeat (2) @(posedge clk);
    @(negedge clk);
  endtask

  // checks in the middle of each game second, away from tick edges
  task automatic play_game(input int secs, input int goal, input bit use_keys, output int hits);
    int         k;
    int         digit;
    logic [8:0] model;
    model = 9'h160;
    hits = 0;
    k = 0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    game_window = 1'b1;
    while (hits < goal && k < secs) begin
      compare("mole pattern", {7'd0, model}, {7'd0, led[15:7]});
      compare("countdown and score", {two_digits(secs - k), two_digits(hits)}, nums);
      if (use_keys) begin
        rng = lcg_next(rng);
        digit = (rng >> 16) % 10;
        press(KEY_CODE[digit + (rng[27] ? 10 : 0)]);
        if (digit != 0 && model[9 - digit]) hits++;
      end
      k++;
      model = lfsr_step(model);
      if (hits < goal && k < secs) begin
        repeat (use_keys ? 12 : 16) @(posedge clk);
        @(negedge clk);
      end
    end
    game_window = 1'b0;
  endtask

  // result codes are the only non-BCD top nibbles
  task automatic wait_result(input logic [15:0] exp);
    int n;
    n = 0;
    @(negedge clk);
    while (nums[15:12] <= 4'd9 && n < 40) begin
      @(negedge clk);
      n++;
    end
    if (nums[15:12] <= 4'd9) begin
      other_errors++;
      $display("%s: no result code appeared after the game ended", test_name);
    end else begin
      compare("result code", exp, nums);
    end
  endtask

  task automatic final_flash(input logic [15:0] exp);
    repeat (8) @(posedge clk);
    @(negedge clk);
    for (int j = 0; j < 5; j++) begin
      compare("flash led", j % 2 == 0 ? 16'hFFFF : 16'h0000, led);
      compare("result held", exp, nums);
      repeat (16) @(posedge clk);
      @(negedge clk);
    end
    compare("idle led", 16'h8001, led);
    compare("idle nums", 16'hFFFF, nums);
  endtask

  initial begin
    check_errors = 0;
    other_errors = 0;
    rng = 32'd6;
    game_window = 1'b0;
    score = 0;
    out_rst = 1'b1;
    start = 1'b0;
    key = '0;
    test_name = "reset and idle";
    repeat (8) @(posedge clk);
    out_rst <= 1'b0;
    settle();
    compare("led", 16'h8001, led);
    compare("nums", 16'hFFFF, nums);

    test_name = "setting entry";
    pulse_start();
    settle();
    compare("led", 16'hFF01, led);
    compare("nums", 16'h3010, nums);
    press(KEY_CODE[4]);
    press(KEY_CODE[5]);
    settle();
    compare("time digits", 16'h4510, nums);
    press(SPACE_CODE);
    settle();
    compare("goal mode led", 16'h80FF, led);
    press(KEY_CODE[10]);  // keypad 0
    send_key(KEY_CODE[3], 1'b1);
    settle();
    compare("goal digits", 16'h4503, nums);
    send_key(KEY_CODE[3], 1'b1);  // still held
    settle();
    compare("typematic repeat", 16'h4503, nums);
    send_key(KEY_CODE[3], 1'b0);
    press(KEY_CODE[3]);
    settle();
    compare("after release", 16'h4533, nums);
    press(KEY_CODE[0]);
    press(KEY_CODE[12]);
    settle();
    compare("goal 02", 16'h4502, nums);

    test_name = "win path";
    pulse_start();
    play_game(45, 2, 1'b1, score);
    wait_result(score == 2 ? 16'hFABC : 16'hD05E);
    test_name = "final flash after win";
    final_flash(score == 2 ? 16'hFABC : 16'hD05E);

    test_name = "loss path";
    pulse_start();
    settle();
    press(KEY_CODE[0]);
    press(KEY_CODE[3]);
    press(SPACE_CODE);
    press(KEY_CODE[19]);
    press(KEY_CODE[9]);
    settle();
    compare("time 03 goal 99", 16'h0399, nums);
    pulse_start();
    play_game(3, 99, 1'b0, score);
    wait_result(16'hD05E);
    test_name = "final flash after loss";
    final_flash(16'hD05E);

    $display("checks failed: %0d, other errors: %0d", check_errors, other_errors);
    if (check_errors == 0 && other_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  initial begin
    #(RUN_TICKS * TICK_CYCLES * CLK_PERIOD);
    $display("watchdog timeout, the run did not finish within %0d ticks", RUN_TICKS);
    $display("checks failed: %0d, other errors: %0d", check_errors, other_errors + 1);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

/* tb.f */
whack_pkg.sv
key_mapper.sv
game_fsm.sv
game_timer.sv
mole_lfsr.sv
score_keeper.sv
led_display.sv
whack_top.sv
tb_whack.sv
